// ==== src/dpi_pkg.sv ====
package dpi_pkg;

   // Stream identifier width, 64 streams
   parameter int STREAM_W = 6;
   parameter int NUM_STREAMS = 1 << STREAM_W;

   // Payload byte width
   parameter int CHAR_W = 8;

   // Per-rule matched packet counter width
   parameter int COUNT_W = 16;

   // Rules evaluated per packet
   parameter int NUM_RULES = 2;

   // Matcher state holds the matched prefix length
   parameter int MSTATE_W = 4;
   // Longest literal the state width can follow
   parameter int PAT_MAX_LEN = (1 << MSTATE_W) - 1;

   // Beat opcodes on the input side
   typedef enum logic [1:0] {
      OP_START = 2'd0,
      OP_CHAR  = 2'd1,
      OP_END   = 2'd2
   } beat_op_e;

   // Framing machine states in the decoder
   typedef enum logic {
      DS_IDLE   = 1'b0,
      DS_IN_PKT = 1'b1
   } dec_state_e;

   // One input beat
   typedef struct packed {
      beat_op_e            op;
      logic [STREAM_W-1:0] stream_id;
      logic [CHAR_W-1:0]   char;
   } pkt_beat_t;

   // Decoded control word, broadcast to all rule contexts
   typedef struct packed {
      logic                 load_state;
      logic                 new_stream;
      logic                 char_vld;
      logic                 eop;
      logic [STREAM_W-1:0]  stream_id;
      logic [CHAR_W-1:0]    char;
      logic [NUM_RULES-1:0] enable;
   } rule_ctl_t;

   // Per-packet result, one bit per rule
   typedef struct packed {
      logic [STREAM_W-1:0]  stream_id;
      logic [NUM_RULES-1:0] match_mask;
   } verdict_t;

endpackage

// ==== src/stream_decoder.sv ====
`timescale 1ns/1ps

module stream_decoder
   import dpi_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_vld,
   input  pkt_beat_t            beat,
   input  logic                 cfg_vld,
   input  logic [STREAM_W-1:0]  cfg_stream,
   input  logic [NUM_RULES-1:0] cfg_mask,
   output rule_ctl_t            ctl
);

   dec_state_e           state;
   logic [STREAM_W-1:0]  open_stream;
   logic [NUM_STREAMS-1:0] seen;
   logic [NUM_RULES-1:0] mask_tbl [NUM_STREAMS];

   logic same_stream;
   logic start_ok;
   logic char_ok;
   logic end_ok;

   // Beat filter, anything not listed here is dropped
   always_comb
   begin
      same_stream = (beat.stream_id == open_stream);
      // START only opens a packet from idle
      start_ok = beat_vld && (state == DS_IDLE) && (beat.op == OP_START);
      // Body and END must belong to the open packet
      char_ok = beat_vld && (state == DS_IN_PKT) && (beat.op == OP_CHAR) && same_stream;
      end_ok = beat_vld && (state == DS_IN_PKT) && (beat.op == OP_END) && same_stream;
   end

   // Framing FSM and seen bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= DS_IDLE;
         open_stream <= '0;
         seen <= '0;
      end
      else
      begin
         if (start_ok)
         begin
            state <= DS_IN_PKT;
            open_stream <= beat.stream_id;
            // First open of a stream marks it for good
            seen[beat.stream_id] <= 1'b1;
         end
         else if (end_ok)
            state <= DS_IDLE;
      end
   end

   // Enable table, written by the config port
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_STREAMS; i++)
            mask_tbl[i] <= '0;
      end
      else if (cfg_vld)
         mask_tbl[cfg_stream] <= cfg_mask;
   end

   // Registered control word
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ctl.load_state <= 1'b0;
         ctl.new_stream <= 1'b0;
         ctl.char_vld <= 1'b0;
         ctl.eop <= 1'b0;
      end
      else
      begin
         ctl.load_state <= start_ok;
         ctl.new_stream <= start_ok && !seen[beat.stream_id];
         ctl.char_vld <= char_ok;
         ctl.eop <= end_ok;
         if (start_ok || char_ok || end_ok)
         begin
            ctl.stream_id <= beat.stream_id;
            ctl.char <= beat.char;
         end
         // Mask is sampled once per packet, at START
         if (start_ok)
            ctl.enable <= mask_tbl[beat.stream_id];
      end
   end

endmodule

// ==== src/literal_matcher.sv ====
`timescale 1ns/1ps

module literal_matcher
   import dpi_pkg::*;
#(
   parameter logic [PAT_MAX_LEN*CHAR_W-1:0] PATTERN = "finger",
   parameter int PAT_LEN = 6
)
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                char_vld,
   input  logic [CHAR_W-1:0]   char_in,
   input  logic                state_in_vld,
   input  logic [MSTATE_W-1:0] state_in,
   output logic [MSTATE_W-1:0] state_out,
   output logic                accept
);

   // State value of the final pattern byte
   localparam logic [MSTATE_W-1:0] LAST = MSTATE_W'(PAT_LEN - 1);
   // First pattern byte, restarts an attempt after a mismatch
   localparam logic [CHAR_W-1:0] FIRST_CHAR = PATTERN[CHAR_W*(PAT_LEN - 1) +: CHAR_W];

   logic [MSTATE_W-1:0] state;
   logic [MSTATE_W-1:0] cur_state;
   logic [CHAR_W-1:0]   exp_char;

   // Byte idx of the literal, first byte sits highest in the parameter
   function automatic logic [CHAR_W-1:0] pat_byte(input logic [MSTATE_W-1:0] idx);
      return PATTERN[CHAR_W*(PAT_LEN - 1 - int'(idx)) +: CHAR_W];
   endfunction

   always_comb
   begin
      // A restored state replaces the register for this cycle
      cur_state = state_in_vld ? state_in : state;
      exp_char = pat_byte(cur_state);
   end

   // Saved by the context at packet end
   assign state_out = cur_state;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= '0;
         accept <= 1'b0;
      end
      else
      begin
         accept <= 1'b0;
         if (char_vld)
         begin
            if (char_in == exp_char)
            begin
               // Full literal seen, pulse and start over
               if (cur_state == LAST)
               begin
                  state <= '0;
                  accept <= 1'b1;
               end
               else
                  state <= cur_state + 1'b1;
            end
            // Mismatch may still start a new attempt
            else if (char_in == FIRST_CHAR)
               state <= MSTATE_W'(1);
            else
               state <= '0;
         end
         else
            state <= cur_state;
      end
   end

endmodule

// ==== src/rule_context.sv ====
`timescale 1ns/1ps

module rule_context
   import dpi_pkg::*;
#(
   parameter logic [PAT_MAX_LEN*CHAR_W-1:0] PATTERN = "finger",
   parameter int PAT_LEN = 6,
   parameter int RULE_IDX = 0
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  rule_ctl_t          ctl,
   output logic               fired_at_eop,
   output logic [COUNT_W-1:0] count
);

   // Saved matcher state per stream
   logic [MSTATE_W-1:0] state_mem [NUM_STREAMS];

   // Restore path towards the matcher
   logic                state_in_vld;
   logic [MSTATE_W-1:0] state_in;

   logic [MSTATE_W-1:0] m_state;
   logic                accept;
   logic                fired_flag;
   logic                fired_val;
   logic                rule_en;

   assign rule_en = ctl.enable[RULE_IDX];

   // Accept of the last byte still counts at eop
   assign fired_val = fired_flag | accept;

   // Restore is presented the cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= ctl.load_state;
   end

   always_ff @(posedge clk)
   begin
      if (ctl.load_state)
      begin
         // Unknown stream starts from scratch
         if (ctl.new_stream)
            state_in <= '0;
         else
            state_in <= state_mem[ctl.stream_id];
      end
   end

   // Save at the end of an enabled packet
   always_ff @(posedge clk)
   begin
      // First open of a stream leaves an empty prefix behind
      if (ctl.load_state && ctl.new_stream)
         state_mem[ctl.stream_id] <= '0;
      else if (ctl.eop && rule_en)
         state_mem[ctl.stream_id] <= m_state;
   end

   // Speculative fired flag, count and eop result
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired_flag <= 1'b0;
         fired_at_eop <= 1'b0;
         count <= '0;
      end
      else
      begin
         fired_at_eop <= 1'b0;
         if (ctl.load_state)
            fired_flag <= 1'b0;
         else if (accept)
            fired_flag <= 1'b1;
         if (ctl.eop)
         begin
            if (rule_en)
            begin
               count <= count + COUNT_W'(fired_val);
               fired_at_eop <= fired_val;
            end
            else
               // Disabled rule reports nothing for this packet
               fired_flag <= 1'b0;
         end
      end
   end

   literal_matcher #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   ) i_matcher (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_vld     (ctl.char_vld),
      .char_in      (ctl.char),
      .state_in_vld (state_in_vld),
      .state_in     (state_in),
      .state_out    (m_state),
      .accept       (accept)
   );

endmodule

// ==== src/verdict_collector.sv ====
`timescale 1ns/1ps

module verdict_collector
   import dpi_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 eop,
   input  logic [STREAM_W-1:0]  stream_id,
   input  logic [NUM_RULES-1:0] fired,
   output logic                 verdict_vld,
   output verdict_t             verdict
);

   // Packet end delayed to meet the rule results
   logic                eop_q;
   logic [STREAM_W-1:0] stream_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         eop_q <= 1'b0;
      else
         eop_q <= eop;
   end

   // Stream id of the closing packet
   always_ff @(posedge clk)
   begin
      if (eop)
         stream_q <= stream_id;
   end

   // Verdict strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         verdict_vld <= 1'b0;
      else
         verdict_vld <= eop_q;
   end

   // Rule bits land one cycle after eop
   always_ff @(posedge clk)
   begin
      if (eop_q)
      begin
         verdict.stream_id <= stream_q;
         verdict.match_mask <= fired;
      end
   end

endmodule

// ==== src/dpi_top.sv ====
`timescale 1ns/1ps

module dpi_top
   import dpi_pkg::*;
#(
   parameter logic [PAT_MAX_LEN*CHAR_W-1:0] PATTERN0 = "finger",
   parameter int PAT_LEN0 = 6,
   parameter logic [PAT_MAX_LEN*CHAR_W-1:0] PATTERN1 = "passwd",
   parameter int PAT_LEN1 = 6
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_vld,
   input  pkt_beat_t            beat,
   input  logic                 cfg_vld,
   input  logic [STREAM_W-1:0]  cfg_stream,
   input  logic [NUM_RULES-1:0] cfg_mask,
   output logic                 verdict_vld,
   output verdict_t             verdict,
   output logic [COUNT_W-1:0]   count0,
   output logic [COUNT_W-1:0]   count1
);

   rule_ctl_t            ctl;
   logic [NUM_RULES-1:0] fired;

   // Framing and per-stream enables
   stream_decoder i_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_vld   (beat_vld),
      .beat       (beat),
      .cfg_vld    (cfg_vld),
      .cfg_stream (cfg_stream),
      .cfg_mask   (cfg_mask),
      .ctl        (ctl)
   );

   // Rule 0
   rule_context #(
      .PATTERN  (PATTERN0),
      .PAT_LEN  (PAT_LEN0),
      .RULE_IDX (0)
   ) i_rule0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctl          (ctl),
      .fired_at_eop (fired[0]),
      .count        (count0)
   );

   // Rule 1
   rule_context #(
      .PATTERN  (PATTERN1),
      .PAT_LEN  (PAT_LEN1),
      .RULE_IDX (1)
   ) i_rule1 (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctl          (ctl),
      .fired_at_eop (fired[1]),
      .count        (count1)
   );

   verdict_collector i_collector (
      .clk         (clk),
      .rst_n       (rst_n),
      .eop         (ctl.eop),
      .stream_id   (ctl.stream_id),
      .fired       (fired),
      .verdict_vld (verdict_vld),
      .verdict     (verdict)
   );

endmodule

// ==== testbench/dpi_model.svh ====
`ifndef DPI_MODEL_SVH
`define DPI_MODEL_SVH

// Expected verdict together with the counts seen alongside it
typedef struct packed {
   verdict_t           v;
   logic [COUNT_W-1:0] c0;
   logic [COUNT_W-1:0] c1;
} exp_t;

string              pats [NUM_RULES];
int unsigned        mem_st [NUM_RULES][NUM_STREAMS];
int unsigned        cur_st [NUM_RULES];
bit                 cur_fired [NUM_RULES];
bit [NUM_STREAMS-1:0] m_seen;
bit [NUM_RULES-1:0] m_mask [NUM_STREAMS];
bit [NUM_RULES-1:0] m_en;
bit                 m_open;
bit [STREAM_W-1:0]  m_stream;
logic [COUNT_W-1:0] m_count [NUM_RULES];
exp_t               exp_q [$];

// Everything back to the post-reset picture
task automatic model_reset();
   pats[0] = "finger";
   pats[1] = "passwd";
   m_seen = '0;
   m_open = 1'b0;
   m_stream = '0;
   m_en = '0;
   for (int s = 0; s < NUM_STREAMS; s++)
      m_mask[s] = '0;
   for (int r = 0; r < NUM_RULES; r++)
   begin
      cur_st[r] = 0;
      cur_fired[r] = 1'b0;
      m_count[r] = '0;
      for (int s = 0; s < NUM_STREAMS; s++)
         mem_st[r][s] = 0;
   end
endtask

// Matched-prefix rule, one byte
task automatic model_step(input int r, input byte c);
   if (c == pats[r][cur_st[r]])
   begin
      // Full literal, count it and start over
      if (cur_st[r] == pats[r].len() - 1)
      begin
         cur_st[r] = 0;
         cur_fired[r] = 1'b1;
      end
      else
         cur_st[r]++;
   end
   else if (c == pats[r][0])
      cur_st[r] = 1;
   else
      cur_st[r] = 0;
endtask

// Framing filter plus rule effects of one beat
task automatic model_beat(input pkt_beat_t b, output bit fin);
   exp_t e;
   fin = 1'b0;
   if (!m_open && b.op == OP_START)
   begin
      m_open = 1'b1;
      m_stream = b.stream_id;
      m_en = m_mask[b.stream_id];
      for (int r = 0; r < NUM_RULES; r++)
      begin
         cur_st[r] = m_seen[b.stream_id] ? mem_st[r][b.stream_id] : 0;
         cur_fired[r] = 1'b0;
      end
      m_seen[b.stream_id] = 1'b1;
   end
   else if (m_open && b.stream_id == m_stream && b.op == OP_CHAR)
   begin
      for (int r = 0; r < NUM_RULES; r++)
         model_step(r, b.char);
   end
   else if (m_open && b.stream_id == m_stream && b.op == OP_END)
   begin
      fin = 1'b1;
      m_open = 1'b0;
      e.v.stream_id = b.stream_id;
      e.v.match_mask = '0;
      // Disabled rule keeps the old saved state and reports nothing
      for (int r = 0; r < NUM_RULES; r++)
      begin
         if (m_en[r])
         begin
            mem_st[r][b.stream_id] = cur_st[r];
            e.v.match_mask[r] = cur_fired[r];
            m_count[r] = m_count[r] + COUNT_W'(cur_fired[r]);
         end
      end
      e.c0 = m_count[0];
      e.c1 = m_count[1];
      exp_q.push_back(e);
   end
endtask

`endif

// ==== testbench/tb_dpi_top.sv ====
`timescale 1ns/1ps

module tb_dpi_top
   import dpi_pkg::*;
();

   localparam int NUM_RAND_PKTS = 200;
   localparam int MAX_PIECES = 6;
   // Upper bound on beats, directed tests included
   localparam int EST_BEATS = 400 + NUM_RAND_PKTS * (MAX_PIECES * 6 + 3);

   logic                 clk;
   logic                 rst_n;
   logic                 beat_vld;
   pkt_beat_t            beat;
   logic                 cfg_vld;
   logic [STREAM_W-1:0]  cfg_stream;
   logic [NUM_RULES-1:0] cfg_mask;
   logic                 verdict_vld;
   verdict_t             verdict;
   logic [COUNT_W-1:0]   count0;
   logic [COUNT_W-1:0]   count1;

   bit       end_sent;
   bit [2:0] end_pipe;
   int       errors;
   int       tests_passed;
   int       tests_failed;

   `include "dpi_model.svh"

   dpi_top i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_vld    (beat_vld),
      .beat        (beat),
      .cfg_vld     (cfg_vld),
      .cfg_stream  (cfg_stream),
      .cfg_mask    (cfg_mask),
      .verdict_vld (verdict_vld),
      .verdict     (verdict),
      .count0      (count0),
      .count1      (count1)
   );

   always #5 clk = ~clk;

   task automatic check_val(input string name, input int unsigned expv, input int unsigned actv);
      assert (expv == actv)
      else
      begin
         $display("Error: time %0t %s expected %0h actual %0h", $time, name, expv, actv);
         errors++;
      end
   endtask

   // Outputs sampled mid-cycle, away from the active edge
   always @(negedge clk)
   begin
      exp_t e;
      if (rst_n)
      begin
         // END driven after edge t shows up as a verdict after edge t+3
         check_val("verdict_vld", end_pipe[2], verdict_vld);
         if (verdict_vld)
         begin
            assert (exp_q.size() > 0)
            else
            begin
               $display("Unexpected verdict at time %0t with no packet pending", $time);
               errors++;
            end
            if (exp_q.size() > 0)
            begin
               e = exp_q.pop_front();
               check_val("verdict.stream_id", e.v.stream_id, verdict.stream_id);
               check_val("verdict.match_mask", e.v.match_mask, verdict.match_mask);
               check_val("count0", e.c0, count0);
               check_val("count1", e.c1, count1);
            end
         end
      end
      end_pipe <= {end_pipe[1:0], end_sent};
   end

   task automatic send_beat(input beat_op_e op, input int s, input byte c);
      bit fin;
      @(posedge clk);
      #1;
      beat_vld = 1'b1;
      beat.op = op;
      beat.stream_id = STREAM_W'(s);
      beat.char = c;
      cfg_vld = 1'b0;
      model_beat(beat, fin);
      end_sent = fin;
   endtask

   task automatic go_idle();
      @(posedge clk);
      #1;
      beat_vld = 1'b0;
      cfg_vld = 1'b0;
      end_sent = 1'b0;
   endtask

   task automatic cfg_write(input int s, input int m);
      @(posedge clk);
      #1;
      beat_vld = 1'b0;
      end_sent = 1'b0;
      cfg_vld = 1'b1;
      cfg_stream = STREAM_W'(s);
      cfg_mask = NUM_RULES'(m);
      m_mask[s] = NUM_RULES'(m);
   endtask

   task automatic send_packet(input int s, input string payload);
      send_beat(OP_START, s, 8'h00);
      for (int i = 0; i < payload.len(); i++)
         send_beat(OP_CHAR, s, payload[i]);
      send_beat(OP_END, s, 8'h00);
   endtask

   // Drain pending verdicts, then log the test
   task automatic finish_test(input string name, input int err_start);
      int waited;
      waited = 0;
      go_idle();
      while (exp_q.size() > 0 && waited < 20)
      begin
         @(posedge clk);
         waited++;
      end
      repeat (4) @(posedge clk);
      if (exp_q.size() > 0)
      begin
         $display("Verdict missing for %0d packets in test %s", exp_q.size(), name);
         errors++;
         exp_q.delete();
      end
      if (errors == err_start)
      begin
         tests_passed++;
         $display("Test %s done, ok", name);
      end
      else
      begin
         tests_failed++;
         $display("Test %s done, %0d errors", name, errors - err_start);
      end
   endtask

   function automatic string rand_payload();
      string frags [6];
      string p;
      int    pieces;
      frags = '{"finger", "passwd", "fin", "ger", "pas", "swd"};
      p = "";
      pieces = $urandom_range(1, MAX_PIECES);
      for (int i = 0; i < pieces; i++)
      begin
         if ($urandom_range(0, 1) == 0)
            p = {p, frags[$urandom_range(0, 5)]};
         else
            p = {p, $sformatf("%c", 8'h61 + $urandom_range(0, 25))};
      end
      return p;
   endfunction

   // Watchdog
   initial
   begin
      #(EST_BEATS * 10 * 4);
      $display("Timeout, watchdog expired before the tests ended");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      int e0;
      void'($urandom(32'h2f59));
      clk = 1'b0;
      rst_n = 1'b0;
      beat_vld = 1'b0;
      beat = '0;
      cfg_vld = 1'b0;
      cfg_stream = '0;
      cfg_mask = '0;
      end_sent = 1'b0;
      end_pipe = '0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      model_reset();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Single match on an enabled stream
      e0 = errors;
      cfg_write(1, 3);
      send_packet(1, "xxfingerxx");
      finish_test("basic_match", e0);

      // Split across packets, new stream, interleaved stream
      e0 = errors;
      cfg_write(2, 1);
      cfg_write(3, 1);
      cfg_write(4, 1);
      cfg_write(5, 1);
      send_packet(2, "abfin");
      send_packet(2, "gerab");
      send_packet(3, "ger");
      send_packet(4, "fin");
      send_packet(5, "ger");
      send_packet(4, "x");
      finish_test("split_packets", e0);

      // Rule 1 off, its state must not survive
      e0 = errors;
      cfg_write(6, 1);
      send_packet(6, "passwd");
      send_packet(6, "pa");
      cfg_write(6, 3);
      send_packet(6, "sswd");
      finish_test("rule_disabled", e0);

      // Illegal beats are dropped
      e0 = errors;
      cfg_write(7, 3);
      send_beat(OP_CHAR, 7, "f");
      send_beat(OP_START, 7, 8'h00);
      send_beat(OP_CHAR, 7, "f");
      send_beat(OP_CHAR, 7, "i");
      send_beat(OP_START, 8, 8'h00);
      send_beat(OP_CHAR, 7, "n");
      send_beat(OP_CHAR, 8, "x");
      send_beat(OP_END, 8, 8'h00);
      send_beat(OP_CHAR, 7, "g");
      send_beat(OP_CHAR, 7, "e");
      send_beat(OP_CHAR, 7, "r");
      send_beat(OP_END, 7, 8'h00);
      finish_test("illegal_beats", e0);

      // Random back-to-back traffic
      e0 = errors;
      for (int p = 0; p < NUM_RAND_PKTS; p++)
      begin
         if ($urandom_range(0, 7) == 0)
            cfg_write($urandom_range(0, 7), $urandom_range(0, 3));
         send_packet($urandom_range(0, 7), rand_payload());
      end
      finish_test("random_traffic", e0);

      $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+testbench
src/dpi_pkg.sv
src/stream_decoder.sv
src/literal_matcher.sv
src/rule_context.sv
src/verdict_collector.sv
src/dpi_top.sv
testbench/tb_dpi_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DPI testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dpi_top -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_dpi_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q '\*\*\* TEST PASSED \*\*\*'; then
   exit 0
fi
exit 1
